// File: list.f
+incdir+.
dcache_pkg.sv
dcache_way_store.sv
dcache_ctrl.sv
dcache_writeback.sv
dcache.sv
dcache_chk.sv
tb_mem_model.sv
tb_dcache.sv

// File: tb_dcache.sv
`default_nettype none
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int RESET_CYCLES  = 5;
    localparam int SWEEP_TIMEOUT = 100;
    localparam int RSP_TIMEOUT   = 1000;
    localparam int SHADOW_WORDS  = 4096;

    typedef struct packed {
        logic     write;
        addr_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
        logic     exp_hit;
        word_t    exp_rdata;
    } entry_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        delay_en;
    logic        ready;
    cpu_req_t    cpu_req;
    cpu_rsp_t    cpu_rsp;
    mem_rd_req_t mem_rd_req;
    mem_rd_rsp_t mem_rd_rsp;
    mem_wr_req_t mem_wr_req;
    mem_wr_rsp_t mem_wr_rsp;
    int          write_bursts;

    entry_t table_q[$];
    word_t  shadow [SHADOW_WORDS];

    dcache i_dcache (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .ready      (ready),
        .cpu_rsp    (cpu_rsp),
        .mem_rd_req (mem_rd_req),
        .mem_rd_rsp (mem_rd_rsp),
        .mem_wr_req (mem_wr_req),
        .mem_wr_rsp (mem_wr_rsp)
    );

    tb_mem_model i_mem (
        .clk          (clk),
        .rst          (rst),
        .delay_en     (delay_en),
        .rd_req       (mem_rd_req),
        .rd_rsp       (mem_rd_rsp),
        .wr_req       (mem_wr_req),
        .wr_rsp       (mem_wr_rsp),
        .write_bursts (write_bursts)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR at %0t: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    function automatic word_t apply_byte_enables(input word_t old_word,
                                                 input word_t new_word,
                                                 input byte_en_t be);
        word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic add_entry(input logic write, input addr_t addr, input word_t wdata,
                             input byte_en_t be, input logic exp_hit);
        entry_t e;
        e.write     = write;
        e.addr      = addr;
        e.wdata     = wdata;
        e.byte_en   = be;
        e.exp_hit   = exp_hit;
        e.exp_rdata = '0;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // Cold reads, each repeated to hit
        add_entry(1'b0, 32'h0000_0104, '0, '0, 1'b0);
        add_entry(1'b0, 32'h0000_0104, '0, '0, 1'b1);
        add_entry(1'b0, 32'h0000_1FFC, '0, '0, 1'b0);
        add_entry(1'b0, 32'h0000_1FF0, '0, '0, 1'b1);
        // Partial writes, first on a miss then on hits
        add_entry(1'b1, 32'h0000_0348, 32'hDEAD_BEEF, 4'b0101, 1'b0);
        add_entry(1'b0, 32'h0000_0348, '0, '0, 1'b1);
        add_entry(1'b1, 32'h0000_0348, 32'h1122_3344, 4'b1000, 1'b1);
        add_entry(1'b1, 32'h0000_034C, 32'hCAFE_F00D, 4'b0011, 1'b1);
        add_entry(1'b0, 32'h0000_0348, '0, '0, 1'b1);
        add_entry(1'b0, 32'h0000_034C, '0, '0, 1'b1);
        // Six dirty lines in set 3 overflow four ways
        for (int k = 0; k < 6; k++) begin
            add_entry(1'b1, addr_t'(32'h68 + k * 32'h200), word_t'(32'hA5A5_0000 + k),
                      k[0] ? 4'b0110 : 4'b1111, 1'b0);
        end
        for (int k = 0; k < 6; k++) begin
            add_entry(1'b0, addr_t'(32'h68 + k * 32'h200), '0, '0, 1'b0);
        end
    endtask

    // Walk the table against the shadow memory
    task automatic fill_expected();
        entry_t e;
        int     idx;
        for (int i = 0; i < table_q.size(); i++) begin
            e   = table_q[i];
            idx = int'(e.addr[13:2]);
            if (e.write) begin
                shadow[idx] = apply_byte_enables(shadow[idx], e.wdata, e.byte_en);
            end else begin
                e.exp_rdata = shadow[idx];
            end
            table_q[i] = e;
        end
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!ready) begin
            if (n >= limit) begin
                stop_with_failure("ready did not rise before the timeout");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic run_entry(input entry_t e);
        int cycles;
        wait_ready(RSP_TIMEOUT);
        cpu_req.valid   = 1'b1;
        cpu_req.write   = e.write;
        cpu_req.addr    = e.addr;
        cpu_req.wdata   = e.wdata;
        cpu_req.byte_en = e.byte_en;
        @(negedge clk);
        cpu_req.valid = 1'b0;
        cycles = 1;
        while (!cpu_rsp.valid) begin
            if (cycles >= RSP_TIMEOUT) begin
                stop_with_failure($sformatf("no response to the request at address %h",
                                            e.addr));
            end
            @(negedge clk);
            cycles++;
        end
        if (!e.write) begin
            check_value("cpu_rsp.rdata", cpu_rsp.rdata, e.exp_rdata);
        end
        if (e.exp_hit) begin
            check_value("hit_latency", cycles, 2);
        end
    endtask

    task automatic run_table();
        for (int i = 0; i < table_q.size(); i++) begin
            run_entry(table_q[i]);
        end
    endtask

    always @(negedge clk) begin
        if (i_dcache.i_chk.fail_cnt != 0) begin
            stop_with_failure("a protocol assertion on dcache failed");
        end
    end

    initial begin
        rst      = 1'b1;
        delay_en = 1'b0;
        cpu_req  = '0;
        for (int i = 0; i < SHADOW_WORDS; i++) begin
            shadow[i] = i_mem.initial_word(addr_t'(i * 4));
        end
        build_table();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Tag sweep has to finish first
        wait_ready(SWEEP_TIMEOUT);
        fill_expected();
        run_table();
        if (write_bursts < 2) begin
            stop_with_failure($sformatf("only %0d write bursts reached memory, %s",
                                        write_bursts, "at least two were due"));
        end

        // Same table again under memory back-pressure
        delay_en = 1'b1;
        fill_expected();
        run_table();
        @(negedge clk);

        if (i_dcache.i_chk.fail_cnt == 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_with_failure("a protocol assertion on dcache failed");
        end
    end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`default_nettype none
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_mem_model
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        delay_en,
    input  mem_rd_req_t rd_req,
    output mem_rd_rsp_t rd_rsp,
    input  mem_wr_req_t wr_req,
    output mem_wr_rsp_t wr_rsp,
    output int          write_bursts
);

    // 16 KB window of word storage
    localparam int WORDS = 4096;

    word_t       mem [WORDS];
    logic [15:0] lfsr = 16'd19;
    logic        rd_active;
    logic        wr_active;
    logic        b_pend;
    addr_t       rd_addr;
    addr_t       wr_addr;
    int          rd_beat;
    int          wr_beat;

    // Odd multiplier keeps every address bit in the pattern
    function automatic word_t initial_word(input addr_t addr);
        return ((addr >> 2) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic int word_index(input addr_t base, input int beat);
        addr_t a;
        a = base + addr_t'(beat * 4);
        return int'((a >> 2) % WORDS);
    endfunction

    // Galois step, one per bit taken
    function automatic logic take_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    // Three in four cycles ready when delays are on
    function automatic logic grant();
        logic a;
        logic b;
        if (!delay_en) begin
            return 1'b1;
        end
        a = take_bit();
        b = take_bit();
        return a | b;
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = initial_word(addr_t'(i * 4));
        end
        rd_rsp = '0;
        wr_rsp = '0;
    end

    // Handshakes are taken on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            rd_active    <= 1'b0;
            wr_active    <= 1'b0;
            b_pend       <= 1'b0;
            rd_beat      <= 0;
            wr_beat      <= 0;
            write_bursts <= 0;
        end else begin
            if (rd_req.ar_valid && rd_rsp.ar_ready) begin
                rd_active <= 1'b1;
                rd_addr   <= rd_req.ar_addr;
                rd_beat   <= 0;
            end
            if (rd_rsp.r_valid && rd_req.r_ready) begin
                rd_beat <= rd_beat + 1;
                if (rd_rsp.r_last) begin
                    rd_active <= 1'b0;
                end
            end
            if (wr_req.aw_valid && wr_rsp.aw_ready) begin
                wr_active <= 1'b1;
                wr_addr   <= wr_req.aw_addr;
                wr_beat   <= 0;
            end
            if (wr_req.w_valid && wr_rsp.w_ready) begin
                mem[word_index(wr_addr, wr_beat)] <= wr_req.w_data;
                wr_beat <= wr_beat + 1;
                if (wr_req.w_last) begin
                    wr_active <= 1'b0;
                    b_pend    <= 1'b1;
                end
            end
            if (wr_rsp.b_valid && wr_req.b_ready) begin
                b_pend       <= 1'b0;
                write_bursts <= write_bursts + 1;
            end
        end
    end

    // Responses change on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            rd_rsp = '0;
            wr_rsp = '0;
        end else begin
            rd_rsp.ar_ready = rd_req.ar_valid && !rd_active && grant();
            rd_rsp.r_valid  = rd_active && grant();
            rd_rsp.r_data   = mem[word_index(rd_addr, rd_beat)];
            rd_rsp.r_last   = (rd_beat == `DC_WORDS_PER_LINE - 1);
            wr_rsp.aw_ready = wr_req.aw_valid && !wr_active && !b_pend && grant();
            wr_rsp.w_ready  = wr_active && grant();
            wr_rsp.b_valid  = b_pend && grant();
        end
    end

endmodule

`default_nettype wire

// File: dcache_chk.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_chk
    import dcache_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        ready,
    input logic        wb_push,
    input cpu_req_t    cpu_req,
    input cpu_rsp_t    cpu_rsp,
    input mem_rd_req_t mem_rd_req,
    input mem_rd_rsp_t mem_rd_rsp,
    input mem_wr_req_t mem_wr_req,
    input mem_wr_rsp_t mem_wr_rsp
);

    // Counts assertion failures for the testbench top
    int fail_cnt = 0;

    logic req_pending;
    logic wb_pending;

    // CPU request outstanding, from acceptance to its response
    always_ff @(posedge clk) begin
        if (rst) begin
            req_pending <= 1'b0;
        end else if (cpu_req.valid && ready) begin
            req_pending <= 1'b1;
        end else if (cpu_rsp.valid) begin
            req_pending <= 1'b0;
        end
    end

    // Victim line in flight, from the push to the write response
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_pending <= 1'b0;
        end else if (wb_push) begin
            wb_pending <= 1'b1;
        end else if (mem_wr_rsp.b_valid && mem_wr_req.b_ready) begin
            wb_pending <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        mem_rd_req.ar_valid && !mem_rd_rsp.ar_ready |=> mem_rd_req.ar_valid)
    else begin
        $error("ar_valid dropped before ar_ready");
        fail_cnt++;
    end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        mem_wr_req.aw_valid && !mem_wr_rsp.aw_ready |=> mem_wr_req.aw_valid)
    else begin
        $error("aw_valid dropped before aw_ready");
        fail_cnt++;
    end

    // CPU side stalled through the whole request
    ready_low_pending: assert property (@(posedge clk) disable iff (rst)
        req_pending |-> !ready)
    else begin
        $error("ready high while a request is outstanding");
        fail_cnt++;
    end

    // A response belongs to an accepted request
    rsp_pending: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp.valid |-> req_pending)
    else begin
        $error("response valid without an outstanding request");
        fail_cnt++;
    end

    // Refill must not overtake a write-back in flight
    ar_after_wb: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_req.ar_valid && (wb_pending || wb_push)))
    else begin
        $error("refill address issued while a victim line is in flight");
        fail_cnt++;
    end

endmodule

bind dcache dcache_chk i_chk (
    .clk        (clk),
    .rst        (rst),
    .ready      (ready),
    .wb_push    (wb_push),
    .cpu_req    (cpu_req),
    .cpu_rsp    (cpu_rsp),
    .mem_rd_req (mem_rd_req),
    .mem_rd_rsp (mem_rd_rsp),
    .mem_wr_req (mem_wr_req),
    .mem_wr_rsp (mem_wr_rsp)
);

`default_nettype wire

// File: dcache.sv
`default_nettype none
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cpu_req_t    cpu_req,
    output logic        ready,
    output cpu_rsp_t    cpu_rsp,
    output mem_rd_req_t mem_rd_req,
    input  mem_rd_rsp_t mem_rd_rsp,
    output mem_wr_req_t mem_wr_req,
    input  mem_wr_rsp_t mem_wr_rsp
);

    // Way array ports
    index_t                    rd_index;
    index_t                    wr_index;
    way_mask_t                 way_we;
    tag_entry_t                wr_tag;
    line_t                     wr_line;
    tag_entry_t [`DC_WAYS-1:0] way_tag;
    line_t      [`DC_WAYS-1:0] way_line;

    // Victim hand-off
    logic  wb_push;
    logic  wb_busy;
    addr_t wb_addr;
    line_t wb_line;

    dcache_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .ready      (ready),
        .cpu_rsp    (cpu_rsp),
        .rd_index   (rd_index),
        .way_tag    (way_tag),
        .way_line   (way_line),
        .way_we     (way_we),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .wr_line    (wr_line),
        .mem_rd_req (mem_rd_req),
        .mem_rd_rsp (mem_rd_rsp),
        .wb_busy    (wb_busy),
        .wb_push    (wb_push),
        .wb_addr    (wb_addr),
        .wb_line    (wb_line)
    );

    dcache_writeback i_writeback (
        .clk        (clk),
        .rst        (rst),
        .wb_push    (wb_push),
        .wb_addr    (wb_addr),
        .wb_line    (wb_line),
        .wb_busy    (wb_busy),
        .mem_wr_req (mem_wr_req),
        .mem_wr_rsp (mem_wr_rsp)
    );

    for (genvar w = 0; w < `DC_WAYS; w++) begin : gen_way
        dcache_way_store i_way (
            .clk      (clk),
            .rst      (rst),
            .rd_index (rd_index),
            .wr_en    (way_we[w]),
            .wr_index (wr_index),
            .wr_tag   (wr_tag),
            .wr_line  (wr_line),
            .rd_tag   (way_tag[w]),
            .rd_line  (way_line[w])
        );
    end

endmodule

`default_nettype wire

// File: dcache_writeback.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_writeback
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_push,
    input  addr_t       wb_addr,
    input  line_t       wb_line,
    output logic        wb_busy,
    output mem_wr_req_t mem_wr_req,
    input  mem_wr_rsp_t mem_wr_rsp
);

    wb_state_t state;
    offset_t   beat_cnt;
    addr_t     addr_q;
    line_t     line_q;
    logic      last_beat;

    assign wb_busy   = (state != WB_IDLE);
    assign last_beat = (state == WB_DATA) && (beat_cnt == LAST_WORD);

    // Burst outputs straight from state and buffer
    always_comb begin
        mem_wr_req.aw_valid = (state == WB_ADDR);
        mem_wr_req.aw_addr  = addr_q;
        mem_wr_req.w_valid  = (state == WB_DATA);
        mem_wr_req.w_data   = line_q[beat_cnt];
        mem_wr_req.w_last   = last_beat;
        // Response is never stalled
        mem_wr_req.b_ready  = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= WB_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (wb_push) begin
                        state <= WB_ADDR;
                    end
                end
                WB_ADDR: begin
                    if (mem_wr_rsp.aw_ready) begin
                        beat_cnt <= '0;
                        state    <= WB_DATA;
                    end
                end
                WB_DATA: begin
                    if (mem_wr_rsp.w_ready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= WB_RESP;
                        end
                    end
                end
                WB_RESP: begin
                    if (mem_wr_rsp.b_valid) begin
                        state <= WB_IDLE;
                    end
                end
                default: begin
                    state <= WB_IDLE;
                end
            endcase
        end
    end

    // One line buffer, loaded only when idle
    always_ff @(posedge clk) begin
        if (state == WB_IDLE && wb_push) begin
            addr_q <= wb_addr;
            line_q <= wb_line;
        end
    end

endmodule

`default_nettype wire

// File: dcache_ctrl.sv
`default_nettype none
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  cpu_req_t                  cpu_req,
    output logic                      ready,
    output cpu_rsp_t                  cpu_rsp,
    output index_t                    rd_index,
    input  tag_entry_t [`DC_WAYS-1:0] way_tag,
    input  line_t      [`DC_WAYS-1:0] way_line,
    output way_mask_t                 way_we,
    output index_t                    wr_index,
    output tag_entry_t                wr_tag,
    output line_t                     wr_line,
    output mem_rd_req_t               mem_rd_req,
    input  mem_rd_rsp_t               mem_rd_rsp,
    input  logic                      wb_busy,
    output logic                      wb_push,
    output addr_t                     wb_addr,
    output line_t                     wb_line
);

    // Galois feedback for x^8 + x^6 + x^5 + x^4 + 1
    localparam logic [7:0] LFSR_TAPS = 8'hB8;

    function automatic word_t merge_word(
        input word_t    old_word,
        input word_t    new_word,
        input byte_en_t be
    );
        word_t result;
        result = old_word;
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic addr_t line_base(input tag_t tag, input index_t index);
        return {tag, index, {(OFFSET_W + BYTE_OFF_W){1'b0}}};
    endfunction

    ctrl_state_t state, state_d;
    cpu_req_t    req_q;
    index_t      sweep_cnt;
    logic [7:0]  lfsr, lfsr_next;
    logic        lfsr_step;
    way_t        victim;
    offset_t     beat_cnt;
    line_t       refill_line;
    logic        rsp_valid_q, rsp_valid_d;
    word_t       rsp_rdata_q, rsp_rdata_d;

    tag_t       req_tag;
    index_t     req_index;
    offset_t    req_offset;
    way_mask_t  hit_mask;
    line_t      hit_line;
    line_t      src_line;
    line_t      merged_line;
    tag_entry_t victim_tag;
    logic       accept;
    logic       beat_taken;

    assign req_tag    = get_tag(req_q.addr);
    assign req_index  = get_index(req_q.addr);
    assign req_offset = get_offset(req_q.addr);

    // No new request in the cycle the response is out
    assign ready  = (state == IDLE) && !rsp_valid_q;
    assign accept = ready && cpu_req.valid;

    assign cpu_rsp.valid = rsp_valid_q;
    assign cpu_rsp.rdata = rsp_rdata_q;

    assign beat_taken = (state == REFILL_DATA) && mem_rd_rsp.r_valid;
    assign lfsr_next  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);

    // Tag compare over all ways
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_mask[w] = way_tag[w].valid && (way_tag[w].tag == req_tag);
            if (hit_mask[w]) begin
                hit_line = hit_line | way_line[w];
            end
        end
    end

    assign victim_tag = way_tag[victim];

    // Hit data in LOOKUP, refilled data in UPDATE
    assign src_line    = (state == UPDATE) ? refill_line : hit_line;
    assign rsp_rdata_d = src_line[req_offset];

    always_comb begin
        merged_line = src_line;
        if (req_q.write) begin
            merged_line[req_offset] = merge_word(src_line[req_offset], req_q.wdata,
                                                 req_q.byte_en);
        end
    end

    always_comb begin
        state_d      = state;
        rd_index     = req_index;
        way_we       = '0;
        wr_index     = req_index;
        wr_tag.valid = 1'b1;
        wr_tag.dirty = req_q.write;
        wr_tag.tag   = req_tag;
        wr_line      = merged_line;

        mem_rd_req.ar_valid = 1'b0;
        mem_rd_req.ar_addr  = line_base(req_tag, req_index);
        mem_rd_req.r_ready  = 1'b0;

        wb_push     = 1'b0;
        wb_addr     = line_base(victim_tag.tag, req_index);
        wb_line     = way_line[victim];
        rsp_valid_d = 1'b0;
        lfsr_step   = 1'b0;

        case (state)
            SWEEP: begin
                way_we   = '1;
                wr_index = sweep_cnt;
                wr_tag   = '0;
                if (sweep_cnt == index_t'(`DC_SETS - 1)) begin
                    state_d = IDLE;
                end
            end
            IDLE: begin
                // Start the way read with the incoming address
                rd_index = get_index(cpu_req.addr);
                if (accept) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (|hit_mask) begin
                    rsp_valid_d = 1'b1;
                    if (req_q.write) begin
                        way_we = hit_mask;
                    end
                    state_d = IDLE;
                end else begin
                    lfsr_step = 1'b1;
                    state_d   = WAIT_WB;
                end
            end
            WAIT_WB: begin
                if (!wb_busy) begin
                    wb_push = victim_tag.valid && victim_tag.dirty;
                    state_d = REFILL_ADDR;
                end
            end
            REFILL_ADDR: begin
                // Held off until any pushed victim has reached memory
                mem_rd_req.ar_valid = !wb_busy;
                if (!wb_busy && mem_rd_rsp.ar_ready) begin
                    state_d = REFILL_DATA;
                end
            end
            REFILL_DATA: begin
                mem_rd_req.r_ready = 1'b1;
                if (mem_rd_rsp.r_valid && mem_rd_rsp.r_last) begin
                    state_d = UPDATE;
                end
            end
            UPDATE: begin
                way_we[victim] = 1'b1;
                rsp_valid_d    = 1'b1;
                state_d        = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= SWEEP;
            sweep_cnt   <= '0;
            lfsr        <= 8'(`DC_LFSR_SEED);
            beat_cnt    <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            state       <= state_d;
            rsp_valid_q <= rsp_valid_d;
            if (state == SWEEP) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
            if (lfsr_step) begin
                lfsr <= lfsr_next;
            end
            if (state == REFILL_ADDR) begin
                beat_cnt <= '0;
            end else if (beat_taken) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Request, victim and line payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req;
        end
        if (lfsr_step) begin
            victim <= lfsr[WAY_W-1:0];
        end
        if (beat_taken) begin
            refill_line[beat_cnt] <= mem_rd_rsp.r_data;
        end
        if (rsp_valid_d) begin
            rsp_rdata_q <= rsp_rdata_d;
        end
    end

endmodule

`default_nettype wire

// File: dcache_way_store.sv
`default_nettype none
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_way_store
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  index_t     rd_index,
    input  logic       wr_en,
    input  index_t     wr_index,
    input  tag_entry_t wr_tag,
    input  line_t      wr_line,
    output tag_entry_t rd_tag,
    output line_t      rd_line
);

    // One way, tags and lines side by side
    tag_entry_t tag_mem [`DC_SETS];
    line_t      line_mem [`DC_SETS];

    // Write port, takes effect on the presenting edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= wr_line;
        end
    end

    // Registered tag read
    // A read to the set being written returns the old entry.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_tag <= '0;
        end else begin
            rd_tag <= tag_mem[rd_index];
        end
    end

    // Registered line read
    always_ff @(posedge clk) begin
        rd_line <= line_mem[rd_index];
    end

endmodule

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none
`include "dcache_settings.svh"

package dcache_pkg;

    // Address split widths
    localparam int BYTE_OFF_W = $clog2(`DC_WORD_W / 8);
    localparam int OFFSET_W   = $clog2(`DC_WORDS_PER_LINE);
    localparam int INDEX_W    = $clog2(`DC_SETS);
    localparam int TAG_W      = `DC_ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;
    localparam int WAY_W      = $clog2(`DC_WAYS);

    typedef logic [`DC_ADDR_W-1:0]   addr_t;
    typedef logic [`DC_WORD_W-1:0]   word_t;
    typedef logic [`DC_WORD_W/8-1:0] byte_en_t;
    typedef word_t [`DC_WORDS_PER_LINE-1:0] line_t;
    typedef logic [INDEX_W-1:0]      index_t;
    typedef logic [OFFSET_W-1:0]     offset_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [WAY_W-1:0]        way_t;
    typedef logic [`DC_WAYS-1:0]     way_mask_t;

    // Position of the final beat in a burst
    localparam offset_t LAST_WORD = offset_t'(`DC_WORDS_PER_LINE - 1);

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic     valid;
        logic     write;
        addr_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
    } mem_rd_req_t;

    typedef struct packed {
        logic  ar_ready;
        logic  r_valid;
        word_t r_data;
        logic  r_last;
    } mem_rd_rsp_t;

    typedef struct packed {
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        word_t w_data;
        logic  w_last;
        logic  b_ready;
    } mem_wr_req_t;

    typedef struct packed {
        logic aw_ready;
        logic w_ready;
        logic b_valid;
    } mem_wr_rsp_t;

    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        LOOKUP,
        WAIT_WB,
        REFILL_ADDR,
        REFILL_DATA,
        UPDATE
    } ctrl_state_t;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP
    } wb_state_t;

    function automatic tag_t get_tag(input addr_t addr);
        return addr[`DC_ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t get_index(input addr_t addr);
        return addr[BYTE_OFF_W + OFFSET_W +: INDEX_W];
    endfunction

    function automatic offset_t get_offset(input addr_t addr);
        return addr[BYTE_OFF_W +: OFFSET_W];
    endfunction

endpackage

`default_nettype wire

// File: dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Cache geometry and bus widths

// Byte address width
`define DC_ADDR_W 32

// Data word width
`define DC_WORD_W 32

// Words in one cache line
`define DC_WORDS_PER_LINE 8

// Associativity
`define DC_WAYS 4

// Sets in every way
`define DC_SETS 16

// Reset value of the victim LFSR, must not be zero
`define DC_LFSR_SEED 90

`endif
